// File: logic/gray_pkg.sv
// gray counter shared definitions
// word width, prefix network sizes, value types and the speed choice

package gray_pkg;

	// counter word width, fixed for the whole design
	localparam int GRAY_WIDTH = 16;

	// the incrementer lookahead covers all bits but the top one
	localparam int PREFIX_WIDTH = GRAY_WIDTH - 1;

	// tree depth of the fast prefix-and
	localparam int PREFIX_LEVELS = $clog2(PREFIX_WIDTH);
	// tree depth of the fast gray to binary network
	localparam int GRAY_LEVELS = $clog2(GRAY_WIDTH);

	// gray coded word
	typedef logic [GRAY_WIDTH-1:0] gray_t;

	// plain binary word
	typedef logic [GRAY_WIDTH-1:0] bin_t;

	// propagate vector in and out of the prefix-and
	typedef logic [PREFIX_WIDTH-1:0] prop_t;

	// last code before the wrap
	// binary all ones maps to only the top gray bit set
	localparam gray_t GRAY_LAST = {1'b1, {(GRAY_WIDTH-1){1'b0}}};

	// prefix architecture
	typedef enum logic {
		// serial ripple chain, smallest area
		SLOW = 1'b0,
		// sklansky tree, log2 depth
		FAST = 1'b1
	} speed_e;

endpackage

// File: logic/prefix_and.sv
// parallel-prefix AND of a propagate vector
// po[i] is the AND of pi[i] down to pi[0]
// serial chain for SLOW, sklansky tree for FAST

module prefix_and
	import gray_pkg::*;
#(
	parameter speed_e speed = FAST
) (
	input  prop_t pi,
	output prop_t po
);

	if (speed == SLOW) begin : g_serial

		// ripple from bit 0 upwards
		always_comb begin
			logic acc;
			acc = 1'b1;
			for (int i = 0; i < PREFIX_WIDTH; i++) begin
				acc = acc & pi[i];
				po[i] = acc;
			end
		end

	end else begin : g_tree

		// one row per tree level
		// row 0 is the raw propagate input
		logic [PREFIX_LEVELS:0][PREFIX_WIDTH-1:0] lvl;

		assign lvl[0] = pi;

		for (genvar k = 0; k < PREFIX_LEVELS; k++) begin : g_level
			for (genvar i = 0; i < PREFIX_WIDTH; i++) begin : g_bit

				// top bit of the lower half of this block
				localparam int SRC = ((i >> k) << k) - 1;

				if (((i >> k) & 1) == 1) begin : g_comb
					// upper half of the block picks up the lower half
					assign lvl[k+1][i] = lvl[k][i] & lvl[k][SRC];
				end else begin : g_pass
					// lower half already complete at this level
					assign lvl[k+1][i] = lvl[k][i];
				end

			end
		end

		// last row holds the full prefix
		assign po = lvl[PREFIX_LEVELS];

	end

endmodule

// File: logic/inc_gray.sv
// gray code incrementer
// parity plus prefix-and lookahead picks the one bit to flip
// parity enters the chain for SLOW, gates the outputs for FAST

module inc_gray
	import gray_pkg::*;
#(
	parameter speed_e speed = FAST
) (
	input  gray_t a,
	output gray_t z
);

	// parity of the gray word, equals the binary lsb
	logic  p;
	// prefix-and in and out
	prop_t pi;
	prop_t po;
	// flip candidates before the parity term
	logic  [GRAY_WIDTH-1:2] t1;
	// final flip mask, exactly one bit set
	gray_t t2;

	assign p = ^a;

	// propagate is the inverted lower bit
	// pi[i] covers a[i-1]
	assign pi[PREFIX_WIDTH-1:1] = ~a[GRAY_WIDTH-3:0];

	// slow form rides the parity through the chain
	if (speed == SLOW) begin : g_pi_slow
		assign pi[0] = p;
	end else begin : g_pi_fast
		assign pi[0] = 1'b1;
	end

	prefix_and #(
		.speed(speed)
	) i_prefix_and (
		.pi(pi),
		.po(po)
	);

	// middle bits flip when the bit below is set and all lower bits clear
	assign t1[GRAY_WIDTH-2:2] = a[GRAY_WIDTH-3:1] & po[GRAY_WIDTH-3:1];

	// top bit ignores a[n-2]
	// it acts as a wrap back to zero
	assign t1[GRAY_WIDTH-1] = po[GRAY_WIDTH-2];

	// fast form applies parity after the tree
	for (genvar i = 2; i < GRAY_WIDTH; i++) begin : g_mask
		if (speed == SLOW) begin : g_slow
			assign t2[i] = t1[i];
		end else begin : g_fast
			assign t2[i] = t1[i] & p;
		end
	end

	// bit 1 flips on odd parity with bit 0 set
	assign t2[1] = a[0] & p;
	// bit 0 flips on even parity
	assign t2[0] = ~p;

	assign z = a ^ t2;

endmodule

// File: logic/gray_to_bin.sv
// gray to binary conversion
// b[i] is the XOR of g[i] and every gray bit above it
// suffix-XOR built as a serial chain or a sklansky tree

module gray_to_bin
	import gray_pkg::*;
#(
	parameter speed_e speed = FAST
) (
	input  gray_t g,
	output bin_t  b
);

	if (speed == SLOW) begin : g_serial

		// ripple from the msb downwards
		always_comb begin
			logic acc;
			acc = 1'b0;
			for (int i = GRAY_WIDTH - 1; i >= 0; i--) begin
				acc = acc ^ g[i];
				b[i] = acc;
			end
		end

	end else begin : g_tree

		// tree rows in reversed bit order
		// index j stands for gray bit n-1-j, so the suffix becomes a prefix
		logic [GRAY_LEVELS:0][GRAY_WIDTH-1:0] lvl;

		for (genvar j = 0; j < GRAY_WIDTH; j++) begin : g_in
			assign lvl[0][j] = g[GRAY_WIDTH-1-j];
		end

		for (genvar k = 0; k < GRAY_LEVELS; k++) begin : g_level
			for (genvar j = 0; j < GRAY_WIDTH; j++) begin : g_bit

				// top bit of the lower half of this block
				localparam int SRC = ((j >> k) << k) - 1;

				if (((j >> k) & 1) == 1) begin : g_comb
					// fold in the finished lower half
					assign lvl[k+1][j] = lvl[k][j] ^ lvl[k][SRC];
				end else begin : g_pass
					assign lvl[k+1][j] = lvl[k][j];
				end

			end
		end

		// undo the bit reversal
		for (genvar j = 0; j < GRAY_WIDTH; j++) begin : g_out
			assign b[GRAY_WIDTH-1-j] = lvl[GRAY_LEVELS][j];
		end

	end

endmodule

// File: logic/gray_counter.sv
// registered gray code counter
// load a binary start value, step by one gray code, or hold
// shows the count as gray and binary, pulses wrapped on rollover

module gray_counter
	import gray_pkg::*;
#(
	parameter speed_e speed = FAST
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  en,
	input  logic  load,
	input  bin_t  load_value,
	output gray_t count_gray,
	output bin_t  count_bin,
	output logic  wrapped
);

	// count register
	gray_t count_q;
	gray_t count_next;

	// next gray code from the incrementer
	gray_t inc_value;

	// gray form of the load value
	gray_t load_gray;

	// step from the last code back to zero
	logic  wrap_hit;
	logic  wrapped_q;

	// binary to gray on load
	// one shift and one xor
	assign load_gray = load_value ^ (load_value >> 1);

	inc_gray #(
		.speed(speed)
	) i_inc_gray (
		.a(count_q),
		.z(inc_value)
	);

	// load has priority over en
	always_comb begin
		if (load) begin
			count_next = load_gray;
		end else if (en) begin
			count_next = inc_value;
		end else begin
			count_next = count_q;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else begin
			count_q <= count_next;
		end
	end

	// a real increment out of binary all ones
	assign wrap_hit = en & ~load & (count_q == GRAY_LAST);

	// pulse lines up with the zero count
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wrapped_q <= 1'b0;
		end else begin
			wrapped_q <= wrap_hit;
		end
	end

	// binary view of the register
	// valid in the same cycle as count_gray
	gray_to_bin #(
		.speed(speed)
	) i_gray_to_bin (
		.g(count_q),
		.b(count_bin)
	);

	assign count_gray = count_q;
	assign wrapped    = wrapped_q;

	// a plain step moves exactly one gray bit
	// checks incrementer and register together
	a_one_bit_step : assert property (
		@(posedge clk) disable iff (!arst_n)
		(en && !load) |=> ($countones(count_gray ^ $past(count_gray)) == 1)
	) else $error("gray step did not change exactly one bit");

	// wrapping takes 2^16 steps, so the pulse is never back to back
	a_wrap_single : assert property (
		@(posedge clk) disable iff (!arst_n)
		wrapped |=> !wrapped
	) else $error("wrapped high two cycles in a row");

	// a wrap lands on zero
	a_wrap_zero : assert property (
		@(posedge clk) disable iff (!arst_n)
		wrapped |-> (count_gray == '0)
	) else $error("wrapped without zero count");

endmodule

// File: verif/tb_clock.sv
// clock and reset source for the gray counter testbench
// 20 ns clock, arst_n held low for the first 10 cycles

module tb_clock (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// half of the 20 ns period
	localparam int HALF_PERIOD_NS = 10;
	localparam int RESET_CYCLES   = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// release lines up with a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// File: verif/tb_gray_counter.sv
// testbench for the gray counter
// directed tests against a binary shadow count
// fast and slow DUTs run side by side on the same inputs

module tb_gray_counter
	import gray_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD_NS = 20;
	localparam int RESET_CYCLES  = 10;
	localparam int COUNT_CYCLES  = 300;
	localparam int HOLD_CYCLES   = 40;
	localparam int RAND_SEQS     = 24;
	localparam int RAND_MAX_RUN  = 32;
	// worst case cycles of all tests together
	localparam int RUN_CYCLES = RESET_CYCLES + 6 + (COUNT_CYCLES + 2) + 8 + 6
		+ (HOLD_CYCLES + 2) + RAND_SEQS * (RAND_MAX_RUN + 2) + 1;
	localparam int MARGIN_CYCLES = 200;

	logic  clk;
	logic  arst_n;
	logic  en;
	logic  load;
	bin_t  load_value;
	gray_t count_gray;
	bin_t  count_bin;
	logic  wrapped;
	// outputs of the serial build
	gray_t slow_gray;
	bin_t  slow_bin;
	logic  slow_wrapped;

	// reference model
	// holds the state after the latest rising edge
	bin_t  shadow;
	logic  exp_wrap;
	logic  last_inc;
	gray_t prev_gray;

	int errors;
	int checks;
	int tests;
	int wrap_seen;
	int seed;

	tb_clock i_tb_clock (
		.clk(clk),
		.arst_n(arst_n)
	);

	gray_counter #(
		.speed(FAST)
	) i_gray_counter (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.load(load),
		.load_value(load_value),
		.count_gray(count_gray),
		.count_bin(count_bin),
		.wrapped(wrapped)
	);

	// serial prefix networks on the same inputs
	gray_counter #(
		.speed(SLOW)
	) i_gray_counter_slow (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.load(load),
		.load_value(load_value),
		.count_gray(slow_gray),
		.count_bin(slow_bin),
		.wrapped(slow_wrapped)
	);

	// binary xor binary shifted right by one
	function automatic gray_t to_gray(input bin_t v);
		return v ^ (v >> 1);
	endfunction

	task automatic report_mismatch(input string what, input bin_t got, input bin_t expected);
		errors++;
		$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, expected);
	endtask

	// sampled at the falling edge where outputs have settled
	task automatic check_outputs();
		checks++;
		if (count_gray !== to_gray(shadow)) begin
			report_mismatch("count_gray", count_gray, to_gray(shadow));
		end
		if (count_bin !== shadow) begin
			report_mismatch("count_bin", count_bin, shadow);
		end
		if (wrapped !== exp_wrap) begin
			report_mismatch("wrapped", bin_t'(wrapped), bin_t'(exp_wrap));
		end
		if (slow_gray !== to_gray(shadow)) begin
			report_mismatch("slow count_gray", slow_gray, to_gray(shadow));
		end
		if (slow_bin !== shadow) begin
			report_mismatch("slow count_bin", slow_bin, shadow);
		end
		if (slow_wrapped !== exp_wrap) begin
			report_mismatch("slow wrapped", bin_t'(slow_wrapped), bin_t'(exp_wrap));
		end
		// a gray step touches one bit only
		if (last_inc && $countones(count_gray ^ prev_gray) != 1) begin
			errors++;
			$display("FAIL at %0t ns: step from %h to %h changed %0d bits", $time,
				prev_gray, count_gray, $countones(count_gray ^ prev_gray));
		end
		if (wrapped === 1'b1) begin
			wrap_seen++;
		end
		prev_gray = count_gray;
	endtask

	// entered at a rising edge, left at the next one
	// the falling edge in between checks the result of the previous edge
	task automatic cycle(input logic e, input logic l, input bin_t v);
		en         <= e;
		load       <= l;
		load_value <= v;
		@(negedge clk);
		check_outputs();
		// load first, then increment, else hold
		if (l) begin
			shadow   = v;
			exp_wrap = 1'b0;
			last_inc = 1'b0;
		end else if (e) begin
			exp_wrap = (shadow == '1);
			shadow   = shadow + bin_t'(1);
			last_inc = 1'b1;
		end else begin
			exp_wrap = 1'b0;
			last_inc = 1'b0;
		end
		@(posedge clk);
	endtask

	// also checks the last step of a test
	task automatic idle_cycle();
		cycle(1'b0, 1'b0, '0);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("%s: done, no errors", name);
		end else begin
			$display("%s: done, %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_reset();
		int errs_before;
		errs_before = errors;
		// still inside reset
		repeat (2) @(negedge clk);
		if (count_gray !== '0 || count_bin !== '0 || wrapped !== 1'b0) begin
			errors++;
			$display("FAIL at %0t ns: outputs not cleared during reset", $time);
		end
		@(posedge arst_n);
		@(posedge clk);
		idle_cycle();
		idle_cycle();
		report_test("reset", errs_before);
	endtask

	task automatic test_count();
		int errs_before;
		errs_before = errors;
		cycle(1'b0, 1'b1, '0);
		repeat (COUNT_CYCLES) cycle(1'b1, 1'b0, '0);
		idle_cycle();
		report_test("count", errs_before);
	endtask

	task automatic test_load();
		int errs_before;
		errs_before = errors;
		cycle(1'b0, 1'b1, 16'h1234);
		// en high as well so load must win
		cycle(1'b1, 1'b1, 16'h0abc);
		cycle(1'b1, 1'b0, '0);
		// steps across 7fff to 8000
		cycle(1'b1, 1'b1, 16'h7ffe);
		cycle(1'b1, 1'b0, '0);
		cycle(1'b1, 1'b0, '0);
		idle_cycle();
		report_test("load", errs_before);
	endtask

	task automatic test_wrap();
		int errs_before;
		int wraps_before;
		errs_before  = errors;
		wraps_before = wrap_seen;
		cycle(1'b0, 1'b1, '1);
		cycle(1'b1, 1'b0, '0);
		// zero count with the pulse, then the pulse drops
		idle_cycle();
		idle_cycle();
		if (wrap_seen - wraps_before != 1) begin
			errors++;
			$display("FAIL at %0t ns: wrapped high for %0d cycles, expected 1", $time,
				wrap_seen - wraps_before);
		end
		report_test("wrap", errs_before);
	endtask

	task automatic test_hold();
		int errs_before;
		errs_before = errors;
		cycle(1'b0, 1'b1, 16'h5a5a);
		repeat (HOLD_CYCLES) idle_cycle();
		// inputs stay idle for one more look at the held value
		@(negedge clk);
		if (count_gray !== to_gray(16'h5a5a)) begin
			report_mismatch("held count_gray", count_gray, to_gray(16'h5a5a));
		end
		@(posedge clk);
		report_test("hold", errs_before);
	endtask

	task automatic test_random();
		int         errs_before;
		int         run_len;
		logic [31:0] r;
		logic [1:0] mode;
		bin_t       v;
		logic       e;
		logic       l;
		errs_before = errors;
		for (int s = 0; s < RAND_SEQS; s++) begin
			r = $random(seed);
			// a quarter of the starts sit just below the wrap
			if (r[1:0] == 2'd0) begin
				v = ~bin_t'(r[7:2]);
			end else begin
				v = r[31:16];
			end
			cycle(1'b0, 1'b1, v);
			r       = $random(seed);
			run_len = 1 + int'(r[4:0]);
			mode    = r[9:8];
			for (int c = 0; c < run_len; c++) begin
				r = $random(seed);
				// mode 0 keeps en high, others toggle it
				e = (mode == 2'd0) ? 1'b1 : r[0];
				// rare reload in the middle of a run
				l = (r[7:4] == 4'd0);
				cycle(e, l, r[31:16]);
			end
		end
		idle_cycle();
		report_test("random", errs_before);
	endtask

	initial begin
		en         = 1'b0;
		load       = 1'b0;
		load_value = '0;
		shadow     = '0;
		exp_wrap   = 1'b0;
		last_inc   = 1'b0;
		prev_gray  = '0;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		wrap_seen  = 0;
		seed       = 32'h203a_a07c;

		test_reset();
		test_count();
		test_load();
		test_wrap();
		test_hold();
		test_random();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// hard stop if a wait never returns
	initial begin
		#((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
		$display("timeout: tests did not finish within %0d cycles",
			RUN_CYCLES + MARGIN_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tb.f
logic/gray_pkg.sv
logic/prefix_and.sv
logic/inc_gray.sv
logic/gray_to_bin.sv
logic/gray_counter.sv
verif/tb_clock.sv
verif/tb_gray_counter.sv

// File: run_sim.sh
#!/bin/sh
# build and run the gray counter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_gray_counter \
	-f tb.f \
	-o sim_gray_counter

# keep the log even when the simulator stops on an assertion
if ./obj_dir/sim_gray_counter > sim.log 2>&1; then
	status=0
else
	status=1
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with an error"
	exit 1
fi
exit 0
